//--- design/biu_read_pkg.sv
// read channel of the cpu bus interface unit
// shared widths, beat structs and state encodings

package biu_read_pkg;

  // bus field widths
  localparam int addr_width  = 40;
  localparam int id_width    = 5;
  localparam int data_width  = 128;
  localparam int resp_width  = 4;
  localparam int len_width   = 2;
  localparam int size_width  = 3;
  localparam int burst_width = 2;

  // the two ids owned by the fetch unit
  localparam logic [id_width-1:0] ifu_id0 = 5'b10000;
  localparam logic [id_width-1:0] ifu_id1 = 5'b10001;

  // one read request as sent on the bus
  typedef struct packed {
    logic [id_width-1:0]    id;
    logic [addr_width-1:0]  addr;
    logic [len_width-1:0]   len;
    logic [size_width-1:0]  size;
    logic [burst_width-1:0] burst;
  } ar_beat_t;

  // one read data beat from the bus
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [resp_width-1:0] resp;
    logic                  last;
  } r_beat_t;

  // consumer of a read beat
  typedef enum logic [1:0] {
    src_lsu_linefill,
    src_lsu_other,
    src_ifu
  } rd_src_e;

  // read acknowledge states
  typedef enum logic [1:0] {
    rack_idle,
    rack_busy,
    rack_full
  } rack_state_e;

endpackage

//--- design/biu_r_slot_if.sv
// one entry of the read data store
// push side writes, pop side clears, the entry holds the beat

interface biu_r_slot_if;
  import biu_read_pkg::*;

  logic    wr_en;
  r_beat_t wr_beat;
  logic    clr_en;
  logic    valid;
  r_beat_t beat;

  // bus capture side
  modport push (
    output wr_en,
    output wr_beat,
    input  valid
  );

  // return routing side
  modport pop (
    output clr_en,
    input  valid,
    input  beat
  );

  // the storage entry itself
  modport slot (
    input  wr_en,
    input  wr_beat,
    input  clr_en,
    output valid,
    output beat
  );

endinterface

//--- design/biu_ar_buffer.sv
// read address buffer
// holds core read requests and offers them to the bus in arrival order

module biu_ar_buffer #(
  parameter int ar_depth = 2
) (
  input  logic                   arcpuclk,
  input  logic                   cpurst_b,
  input  logic                   req_valid,
  input  biu_read_pkg::ar_beat_t req_beat,
  output logic                   req_ready,
  output logic                   bus_valid,
  output biu_read_pkg::ar_beat_t bus_beat,
  input  logic                   bus_ready
);
  import biu_read_pkg::*;

  localparam int ptr_width = (ar_depth > 1) ? $clog2(ar_depth) : 1;

  logic [ar_depth-1:0]  ent_vld;
  ar_beat_t             ent_beat [ar_depth];
  logic [ptr_width-1:0] crt_ptr;
  logic [ptr_width-1:0] pop_ptr;
  logic                 req_take;
  logic                 bus_take;

  // free entry available
  assign req_ready = ~&ent_vld;
  assign req_take  = req_valid && req_ready;

  // oldest entry faces the bus
  assign bus_valid = ent_vld[pop_ptr];
  assign bus_beat  = ent_beat[pop_ptr];
  assign bus_take  = bus_valid && bus_ready;

  //**************************************************************************
  // create and pop pointers
  //**************************************************************************
  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      crt_ptr <= '0;
    else if (req_take)
      crt_ptr <= (crt_ptr == ptr_width'(ar_depth - 1)) ? '0 : crt_ptr + 1'b1;
  end

  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pop_ptr <= '0;
    else if (bus_take)
      pop_ptr <= (pop_ptr == ptr_width'(ar_depth - 1)) ? '0 : pop_ptr + 1'b1;
  end

  //**************************************************************************
  // entry flags and payload
  //**************************************************************************
  // create and pop never hit the same entry in one cycle
  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ent_vld <= '0;
    else
    begin
      if (req_take)
        ent_vld[crt_ptr] <= 1'b1;
      if (bus_take)
        ent_vld[pop_ptr] <= 1'b0;
    end
  end

  always_ff @(posedge arcpuclk)
  begin
    if (req_take)
      ent_beat[crt_ptr] <= req_beat;
  end

endmodule

//--- design/biu_r_push_ctl.sv
// read data push control
// accepts bus read beats and writes each one into the next free entry

module biu_r_push_ctl #(
  parameter int r_depth = 2
) (
  input  logic                  arcpuclk,
  input  logic                  cpurst_b,
  input  logic                  bus_valid,
  input  biu_read_pkg::r_beat_t bus_beat,
  output logic                  bus_ready,
  biu_r_slot_if.push            slots [r_depth]
);

  localparam int ptr_width = (r_depth > 1) ? $clog2(r_depth) : 1;

  logic [r_depth-1:0]   slot_vld;
  logic [ptr_width-1:0] crt_ptr;
  logic                 push_en;

  // entries fill in ring order, so the one under crt_ptr is free when ready
  for (genvar i = 0; i < r_depth; i++)
  begin : g_push
    assign slot_vld[i]      = slots[i].valid;
    assign slots[i].wr_en   = push_en && (crt_ptr == ptr_width'(i));
    assign slots[i].wr_beat = bus_beat;
  end

  assign bus_ready = ~&slot_vld;
  assign push_en   = bus_valid && bus_ready;

  // create pointer
  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      crt_ptr <= '0;
    else if (push_en)
      crt_ptr <= (crt_ptr == ptr_width'(r_depth - 1)) ? '0 : crt_ptr + 1'b1;
  end

endmodule

//--- design/biu_r_slot.sv
// read data store entry
// one captured bus beat and its valid flag

module biu_r_slot (
  input logic        arcpuclk,
  input logic        cpurst_b,
  biu_r_slot_if.slot port
);

  //**************************************************************************
  // valid flag
  //**************************************************************************
  // set on capture, cleared when the router hands the beat on
  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      port.valid <= 1'b0;
    else if (port.wr_en)
      port.valid <= 1'b1;
    else if (port.clr_en)
      port.valid <= 1'b0;
  end

  //**************************************************************************
  // beat payload
  //**************************************************************************
  // held stable while the consumer stalls
  always_ff @(posedge arcpuclk)
  begin
    if (port.wr_en)
      port.beat <= port.wr_beat;
  end

endmodule

//--- design/biu_r_route.sv
// read data router
// presents the oldest captured beat to the fetch or load unit,
// decides when it leaves and flags each last beat for the acknowledge

module biu_r_route #(
  parameter int r_depth = 2
) (
  input  logic                                 arcpuclk,
  input  logic                                 cpurst_b,
  input  logic                                 rack_full,
  input  logic                                 lsu_linefill_ready,
  input  logic                                 ifu_ready,
  biu_r_slot_if.pop                            slots [r_depth],
  // load unit return
  output logic                                 lsu_vld,
  output logic [biu_read_pkg::id_width-1:0]    lsu_id,
  output logic [biu_read_pkg::data_width-1:0]  lsu_data,
  output logic [biu_read_pkg::resp_width-1:0]  lsu_resp,
  output logic                                 lsu_last,
  // fetch unit return
  output logic                                 ifu_vld,
  output logic                                 ifu_id,
  output logic [biu_read_pkg::data_width-1:0]  ifu_data,
  output logic [1:0]                           ifu_resp,
  output logic                                 ifu_last,
  output logic                                 rlast_done
);
  import biu_read_pkg::*;

  localparam int ptr_width = (r_depth > 1) ? $clog2(r_depth) : 1;

  logic [r_depth-1:0]   slot_vld;
  r_beat_t              slot_beat [r_depth];
  logic [ptr_width-1:0] pop_ptr;
  logic                 cur_vld;
  r_beat_t              cur_beat;
  rd_src_e              cur_src;
  logic                 src_accept;
  logic                 pop_en;

  for (genvar i = 0; i < r_depth; i++)
  begin : g_pop
    assign slot_vld[i]     = slots[i].valid;
    assign slot_beat[i]    = slots[i].beat;
    assign slots[i].clr_en = pop_en && (pop_ptr == ptr_width'(i));
  end

  // oldest entry
  assign cur_vld  = slot_vld[pop_ptr];
  assign cur_beat = slot_beat[pop_ptr];

  //**************************************************************************
  // classify by read id
  //**************************************************************************
  always_comb
  begin
    if ((cur_beat.id == ifu_id0) || (cur_beat.id == ifu_id1))
      cur_src = src_ifu;
    else if (cur_beat.id[id_width-1 -: 2] == 2'b00)
      cur_src = src_lsu_linefill;
    else
      cur_src = src_lsu_other;
  end

  // only linefill and fetch wait for their consumer
  always_comb
  begin
    case (cur_src)
      src_ifu:          src_accept = ifu_ready;
      src_lsu_linefill: src_accept = lsu_linefill_ready;
      default:          src_accept = 1'b1;
    endcase
  end

  // delivery stalls entirely while an acknowledge is pending
  assign pop_en     = cur_vld && !rack_full && src_accept;
  assign rlast_done = pop_en && cur_beat.last;

  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pop_ptr <= '0;
    else if (pop_en)
      pop_ptr <= (pop_ptr == ptr_width'(r_depth - 1)) ? '0 : pop_ptr + 1'b1;
  end

  //**************************************************************************
  // return ports
  //**************************************************************************
  assign lsu_vld  = cur_vld && !rack_full && (cur_src != src_ifu);
  assign lsu_id   = cur_beat.id;
  assign lsu_data = cur_beat.data;
  assign lsu_resp = cur_beat.resp;
  assign lsu_last = cur_beat.last;

  // fetch sees only the id low bit and okay/error part of resp
  assign ifu_vld  = cur_vld && !rack_full && (cur_src == src_ifu);
  assign ifu_id   = cur_beat.id[0];
  assign ifu_data = cur_beat.data;
  assign ifu_resp = cur_beat.resp[1:0];
  assign ifu_last = cur_beat.last;

endmodule

//--- design/biu_rack_gen.sv
// read acknowledge generator
// raises rack after each delivered last beat, keeps one more pending

module biu_rack_gen (
  input  logic arcpuclk,
  input  logic cpurst_b,
  input  logic rlast_done,
  input  logic rack_ready,
  output logic rack,
  output logic rack_full,
  output logic busy
);
  import biu_read_pkg::*;

  rack_state_e state;
  rack_state_e next_state;

  always_ff @(posedge arcpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= rack_idle;
    else
      state <= next_state;
  end

  // busy holds one acknowledge and full holds a second one
  always_comb
  begin
    next_state = state;
    case (state)
      rack_idle:
        if (rlast_done)
          next_state = rack_busy;
      rack_busy:
        if (rlast_done && !rack_ready)
          next_state = biu_read_pkg::rack_full;
        else if (rack_ready && !rlast_done)
          next_state = rack_idle;
      biu_read_pkg::rack_full:
        if (rack_ready)
          next_state = rack_busy;
      default:
        next_state = rack_idle;
    endcase
  end

  assign rack      = (state != rack_idle);
  assign rack_full = (state == biu_read_pkg::rack_full);
  assign busy      = (state != rack_idle);

endmodule

//--- design/biu_read_channel.sv
// cpu bus interface unit, read channel
// buffers core read requests toward the bus, captures read beats,
// routes them to the fetch or load unit and raises the read acknowledge

module biu_read_channel #(
  parameter int ar_depth = 2,
  parameter int r_depth  = 2
) (
  input  logic                                  arcpuclk,
  input  logic                                  cpurst_b,
  // core request side
  input  logic                                  arvalid,
  input  logic [biu_read_pkg::id_width-1:0]     arid,
  input  logic [biu_read_pkg::addr_width-1:0]   araddr,
  input  logic [biu_read_pkg::len_width-1:0]    arlen,
  input  logic [biu_read_pkg::size_width-1:0]   arsize,
  input  logic [biu_read_pkg::burst_width-1:0]  arburst,
  output logic                                  arready,
  // bus address side
  output logic                                  biu_pad_arvalid,
  output logic [biu_read_pkg::id_width-1:0]     biu_pad_arid,
  output logic [biu_read_pkg::addr_width-1:0]   biu_pad_araddr,
  output logic [biu_read_pkg::len_width-1:0]    biu_pad_arlen,
  output logic [biu_read_pkg::size_width-1:0]   biu_pad_arsize,
  output logic [biu_read_pkg::burst_width-1:0]  biu_pad_arburst,
  input  logic                                  pad_biu_arready,
  // bus data side
  input  logic                                  pad_biu_rvalid,
  input  logic [biu_read_pkg::id_width-1:0]     pad_biu_rid,
  input  logic [biu_read_pkg::data_width-1:0]   pad_biu_rdata,
  input  logic [biu_read_pkg::resp_width-1:0]   pad_biu_rresp,
  input  logic                                  pad_biu_rlast,
  output logic                                  biu_pad_rready,
  // bus acknowledge
  output logic                                  biu_pad_rack,
  input  logic                                  pad_biu_rack_ready,
  // load return
  output logic                                  biu_lsu_r_vld,
  output logic [biu_read_pkg::id_width-1:0]     biu_lsu_r_id,
  output logic [biu_read_pkg::data_width-1:0]   biu_lsu_r_data,
  output logic [biu_read_pkg::resp_width-1:0]   biu_lsu_r_resp,
  output logic                                  biu_lsu_r_last,
  input  logic                                  lsu_biu_r_linefill_ready,
  // fetch return
  output logic                                  biu_ifu_rd_data_vld,
  output logic                                  biu_ifu_rd_id,
  output logic [biu_read_pkg::data_width-1:0]   biu_ifu_rd_data,
  output logic [1:0]                            biu_ifu_rd_resp,
  output logic                                  biu_ifu_rd_last,
  input  logic                                  ifu_biu_r_ready,
  // status
  output logic                                  read_busy
);
  import biu_read_pkg::*;

  ar_beat_t           ar_req_beat;
  ar_beat_t           ar_bus_beat;
  r_beat_t            r_bus_beat;
  logic [r_depth-1:0] r_occ;
  logic               rlast_done;
  logic               rack_full;
  logic               rack_busy;

  biu_r_slot_if slot_if [r_depth] ();

  //**************************************************************************
  // read address path
  //**************************************************************************
  assign ar_req_beat.id    = arid;
  assign ar_req_beat.addr  = araddr;
  assign ar_req_beat.len   = arlen;
  assign ar_req_beat.size  = arsize;
  assign ar_req_beat.burst = arburst;

  biu_ar_buffer #(
    .ar_depth (ar_depth)
  ) ar_buffer_inst (
    .arcpuclk  (arcpuclk),
    .cpurst_b  (cpurst_b),
    .req_valid (arvalid),
    .req_beat  (ar_req_beat),
    .req_ready (arready),
    .bus_valid (biu_pad_arvalid),
    .bus_beat  (ar_bus_beat),
    .bus_ready (pad_biu_arready)
  );

  assign biu_pad_arid    = ar_bus_beat.id;
  assign biu_pad_araddr  = ar_bus_beat.addr;
  assign biu_pad_arlen   = ar_bus_beat.len;
  assign biu_pad_arsize  = ar_bus_beat.size;
  assign biu_pad_arburst = ar_bus_beat.burst;

  //**************************************************************************
  // read data path
  //**************************************************************************
  assign r_bus_beat.id   = pad_biu_rid;
  assign r_bus_beat.data = pad_biu_rdata;
  assign r_bus_beat.resp = pad_biu_rresp;
  assign r_bus_beat.last = pad_biu_rlast;

  biu_r_push_ctl #(
    .r_depth (r_depth)
  ) r_push_ctl_inst (
    .arcpuclk  (arcpuclk),
    .cpurst_b  (cpurst_b),
    .bus_valid (pad_biu_rvalid),
    .bus_beat  (r_bus_beat),
    .bus_ready (biu_pad_rready),
    .slots     (slot_if)
  );

  // data store entries
  for (genvar i = 0; i < r_depth; i++)
  begin : g_slot
    biu_r_slot r_slot_inst (
      .arcpuclk (arcpuclk),
      .cpurst_b (cpurst_b),
      .port     (slot_if[i])
    );
    assign r_occ[i] = slot_if[i].valid;
  end

  biu_r_route #(
    .r_depth (r_depth)
  ) r_route_inst (
    .arcpuclk           (arcpuclk),
    .cpurst_b           (cpurst_b),
    .rack_full          (rack_full),
    .lsu_linefill_ready (lsu_biu_r_linefill_ready),
    .ifu_ready          (ifu_biu_r_ready),
    .slots              (slot_if),
    .lsu_vld            (biu_lsu_r_vld),
    .lsu_id             (biu_lsu_r_id),
    .lsu_data           (biu_lsu_r_data),
    .lsu_resp           (biu_lsu_r_resp),
    .lsu_last           (biu_lsu_r_last),
    .ifu_vld            (biu_ifu_rd_data_vld),
    .ifu_id             (biu_ifu_rd_id),
    .ifu_data           (biu_ifu_rd_data),
    .ifu_resp           (biu_ifu_rd_resp),
    .ifu_last           (biu_ifu_rd_last),
    .rlast_done         (rlast_done)
  );

  biu_rack_gen rack_gen_inst (
    .arcpuclk   (arcpuclk),
    .cpurst_b   (cpurst_b),
    .rlast_done (rlast_done),
    .rack_ready (pad_biu_rack_ready),
    .rack       (biu_pad_rack),
    .rack_full  (rack_full),
    .busy       (rack_busy)
  );

  // any request, beat or acknowledge still in flight
  assign read_busy = biu_pad_arvalid || (|r_occ) || rack_busy;

endmodule

//--- test/biu_read_channel_asserts.sv
// concurrent checks on the read channel top level
// request hold on the bus, one consumer per beat, stall while pending

module biu_read_channel_asserts (
  input logic                                      arcpuclk,
  input logic                                      cpurst_b,
  input logic                                      biu_pad_arvalid,
  input logic                                      pad_biu_arready,
  input logic [$bits(biu_read_pkg::ar_beat_t)-1:0] ar_fields,
  input logic                                      biu_lsu_r_vld,
  input logic                                      biu_ifu_rd_data_vld,
  input logic                                      rack_full
);

  // request stays put until the bus takes it
  property ar_held;
    @(posedge arcpuclk) disable iff (!cpurst_b)
      (biu_pad_arvalid && !pad_biu_arready) |=> (biu_pad_arvalid && $stable(ar_fields));
  endproperty

  ar_held_chk: assert property (ar_held)
    else $error("read request dropped or changed before pad_biu_arready");

  // a beat goes to one consumer only
  one_return_chk: assert property (
    @(posedge arcpuclk) disable iff (!cpurst_b)
      !(biu_lsu_r_vld && biu_ifu_rd_data_vld))
    else $error("load and fetch return valid high together");

  // pending acknowledge blocks all delivery
  rack_stall_chk: assert property (
    @(posedge arcpuclk) disable iff (!cpurst_b)
      rack_full |-> (!biu_lsu_r_vld && !biu_ifu_rd_data_vld))
    else $error("return valid high while an acknowledge is pending");

endmodule

bind biu_read_channel biu_read_channel_asserts asserts_inst (
  .arcpuclk            (arcpuclk),
  .cpurst_b            (cpurst_b),
  .biu_pad_arvalid     (biu_pad_arvalid),
  .pad_biu_arready     (pad_biu_arready),
  .ar_fields           ({biu_pad_arid, biu_pad_araddr, biu_pad_arlen,
                         biu_pad_arsize, biu_pad_arburst}),
  .biu_lsu_r_vld       (biu_lsu_r_vld),
  .biu_ifu_rd_data_vld (biu_ifu_rd_data_vld),
  .rack_full           (rack_full)
);

//--- test/tb_biu_read_channel.sv
// testbench for the read channel of the cpu bus interface unit
// random and directed read traffic checked against a reference model,
// with scoreboards for the address and data paths and a watchdog

module tb_biu_read_channel;
  import biu_read_pkg::*;

  localparam int ar_depth = 2;
  localparam int r_depth  = 2;
  localparam int n_ar     = 24;
  localparam int n_mixed  = 40;
  localparam int n_dir    = 13;
  localparam int n_total  = n_ar + n_mixed + n_dir;

  // what a consumer should see for one beat
  typedef struct packed {
    rd_src_e               dest;
    logic [id_width-1:0]   vis_id;
    logic [resp_width-1:0] vis_resp;
  } route_t;

  logic                   arcpuclk;
  logic                   cpurst_b;
  logic                   arvalid;
  logic [id_width-1:0]    arid;
  logic [addr_width-1:0]  araddr;
  logic [len_width-1:0]   arlen;
  logic [size_width-1:0]  arsize;
  logic [burst_width-1:0] arburst;
  logic                   arready;
  logic                   biu_pad_arvalid;
  logic [id_width-1:0]    biu_pad_arid;
  logic [addr_width-1:0]  biu_pad_araddr;
  logic [len_width-1:0]   biu_pad_arlen;
  logic [size_width-1:0]  biu_pad_arsize;
  logic [burst_width-1:0] biu_pad_arburst;
  logic                   pad_biu_arready;
  logic                   pad_biu_rvalid;
  logic [id_width-1:0]    pad_biu_rid;
  logic [data_width-1:0]  pad_biu_rdata;
  logic [resp_width-1:0]  pad_biu_rresp;
  logic                   pad_biu_rlast;
  logic                   biu_pad_rready;
  logic                   biu_pad_rack;
  logic                   pad_biu_rack_ready;
  logic                   biu_lsu_r_vld;
  logic [id_width-1:0]    biu_lsu_r_id;
  logic [data_width-1:0]  biu_lsu_r_data;
  logic [resp_width-1:0]  biu_lsu_r_resp;
  logic                   biu_lsu_r_last;
  logic                   lsu_biu_r_linefill_ready;
  logic                   biu_ifu_rd_data_vld;
  logic                   biu_ifu_rd_id;
  logic [data_width-1:0]  biu_ifu_rd_data;
  logic [1:0]             biu_ifu_rd_resp;
  logic                   biu_ifu_rd_last;
  logic                   ifu_biu_r_ready;
  logic                   read_busy;

  // ready probabilities in percent
  localparam int arready_pct = 50;
  int lf_pct      = 50;
  int ifu_pct     = 50;
  int rack_pct    = 50;

  // scoreboards and model state
  ar_beat_t ar_q [$];
  r_beat_t  r_q [$];
  int       ar_cnt    = 0;
  int       rack_cnt  = 0;
  int       last_cnt  = 0;
  int       ack_done  = 0;
  int       pend_seen = 0;
  int       full_seen = 0;

  biu_read_channel #(
    .ar_depth (ar_depth),
    .r_depth  (r_depth)
  ) biu_read_channel_inst (.*);

  initial
  begin
    arcpuclk = 1'b0;
    forever #20 arcpuclk = ~arcpuclk;
  end

  //**************************************************************************
  // reference and helpers
  //**************************************************************************
  // destination, visible id and response of one beat
  function automatic route_t expect_route(r_beat_t b);
    route_t r;
    if ((b.id == 5'b10000) || (b.id == 5'b10001))
    begin
      r.dest     = src_ifu;
      r.vis_id   = {4'b0000, b.id[0]};
      r.vis_resp = {2'b00, b.resp[1:0]};
    end
    else
    begin
      r.dest     = (b.id[4:3] == 2'b00) ? src_lsu_linefill : src_lsu_other;
      r.vis_id   = b.id;
      r.vis_resp = b.resp;
    end
    return r;
  endfunction

  // 0 linefill, 1 other load, 2 fetch, 3 any
  function automatic logic [id_width-1:0] pick_id(int cls);
    logic [id_width-1:0] id;
    int                  c;
    c = (cls == 3) ? $urandom_range(0, 2) : cls;
    case (c)
      0: id = {2'b00, 3'($urandom_range(0, 7))};
      1:
      begin
        id = 5'($urandom_range(8, 31));
        if ((id == 5'b10000) || (id == 5'b10001))
          id = 5'b10010;
      end
      default: id = {4'b1000, 1'($urandom_range(0, 1))};
    endcase
    return id;
  endfunction

  task automatic check_value(string name, logic [137:0] got, logic [137:0] exp);
    if (got !== exp)
    begin
      $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic send_requests(int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge arcpuclk);
      arvalid <= 1'b1;
      arid    <= 5'($urandom);
      araddr  <= {8'($urandom), 32'($urandom)};
      arlen   <= 2'($urandom);
      arsize  <= 3'($urandom);
      arburst <= 2'($urandom);
      @(negedge arcpuclk);
      while (!arready)
        @(negedge arcpuclk);
    end
    @(posedge arcpuclk);
    arvalid <= 1'b0;
  endtask

  task automatic send_beats(int n, int cls, bit force_last);
    for (int i = 0; i < n; i++)
    begin
      @(posedge arcpuclk);
      pad_biu_rvalid <= 1'b1;
      pad_biu_rid    <= pick_id(cls);
      pad_biu_rdata  <= {$urandom, $urandom, $urandom, $urandom};
      pad_biu_rresp  <= 4'($urandom);
      pad_biu_rlast  <= force_last || ($urandom_range(0, 1) == 1);
      @(negedge arcpuclk);
      while (!biu_pad_rready)
        @(negedge arcpuclk);
    end
    @(posedge arcpuclk);
    pad_biu_rvalid <= 1'b0;
  endtask

  task automatic wait_drain();
    while ((ar_cnt > 0) || (r_q.size() > 0) || (rack_cnt > 0))
      @(negedge arcpuclk);
    repeat (2) @(negedge arcpuclk);
  endtask

  // random ready levels from the bus and the consumers
  always @(posedge arcpuclk)
  begin
    pad_biu_arready          <= ($urandom_range(0, 99) < arready_pct);
    lsu_biu_r_linefill_ready <= ($urandom_range(0, 99) < lf_pct);
    ifu_biu_r_ready          <= ($urandom_range(0, 99) < ifu_pct);
    pad_biu_rack_ready       <= ($urandom_range(0, 99) < rack_pct);
  end

  //**************************************************************************
  // compare once per cycle on the falling edge
  //**************************************************************************
  always @(negedge arcpuclk)
  begin : compare
    r_beat_t head;
    r_beat_t cap;
    route_t  rt;
    logic    exp_lsu;
    logic    exp_ifu;
    logic    leave;
    logic    leave_last;
    if (cpurst_b)
    begin
      exp_lsu    = 1'b0;
      exp_ifu    = 1'b0;
      leave      = 1'b0;
      leave_last = 1'b0;
      check_value("read_busy", read_busy, (ar_cnt > 0) || (r_q.size() > 0) || (rack_cnt > 0));
      check_value("arready", arready, ar_cnt < ar_depth);
      check_value("biu_pad_arvalid", biu_pad_arvalid, ar_cnt > 0);
      check_value("biu_pad_rready", biu_pad_rready, r_q.size() < r_depth);
      check_value("biu_pad_rack", biu_pad_rack, rack_cnt > 0);
      if (r_q.size() == r_depth)
        full_seen++;
      // address path
      if (biu_pad_arvalid && pad_biu_arready)
      begin
        check_value("biu_pad_arid", biu_pad_arid, ar_q[0].id);
        check_value("biu_pad_araddr", biu_pad_araddr, ar_q[0].addr);
        check_value("biu_pad_arlen", biu_pad_arlen, ar_q[0].len);
        check_value("biu_pad_arsize", biu_pad_arsize, ar_q[0].size);
        check_value("biu_pad_arburst", biu_pad_arburst, ar_q[0].burst);
        void'(ar_q.pop_front());
        ar_cnt--;
      end
      if (arvalid && arready)
      begin
        ar_q.push_back(ar_beat_t'{id: arid, addr: araddr, len: arlen,
                                  size: arsize, burst: arburst});
        ar_cnt++;
      end
      // nothing is offered to either unit while an acknowledge is pending
      if ((r_q.size() > 0) && (rack_cnt < 2))
      begin
        head    = r_q[0];
        rt      = expect_route(head);
        exp_ifu = (rt.dest == src_ifu);
        exp_lsu = !exp_ifu;
      end
      check_value("biu_lsu_r_vld", biu_lsu_r_vld, exp_lsu);
      check_value("biu_ifu_rd_data_vld", biu_ifu_rd_data_vld, exp_ifu);
      if (exp_lsu)
      begin
        check_value("biu_lsu_r_id", biu_lsu_r_id, rt.vis_id);
        check_value("biu_lsu_r_data", biu_lsu_r_data, head.data);
        check_value("biu_lsu_r_resp", biu_lsu_r_resp, rt.vis_resp);
        check_value("biu_lsu_r_last", biu_lsu_r_last, head.last);
        leave = (rt.dest == src_lsu_other) || lsu_biu_r_linefill_ready;
      end
      if (exp_ifu)
      begin
        check_value("biu_ifu_rd_id", biu_ifu_rd_id, rt.vis_id);
        check_value("biu_ifu_rd_data", biu_ifu_rd_data, head.data);
        check_value("biu_ifu_rd_resp", biu_ifu_rd_resp, rt.vis_resp);
        check_value("biu_ifu_rd_last", biu_ifu_rd_last, head.last);
        leave = ifu_biu_r_ready;
      end
      if (leave)
      begin
        leave_last = head.last;
        void'(r_q.pop_front());
        if (head.last)
          last_cnt++;
      end
      if (pad_biu_rvalid && biu_pad_rready)
      begin
        cap.id   = pad_biu_rid;
        cap.data = pad_biu_rdata;
        cap.resp = pad_biu_rresp;
        cap.last = pad_biu_rlast;
        r_q.push_back(cap);
      end
      // acknowledge model with 0 idle, 1 raised and 2 raised plus one pending
      if (biu_pad_rack && pad_biu_rack_ready)
        ack_done++;
      if (rack_cnt == 0)
      begin
        if (leave_last)
          rack_cnt = 1;
      end
      else if (rack_cnt == 1)
      begin
        if (leave_last && !pad_biu_rack_ready)
          rack_cnt = 2;
        else if (pad_biu_rack_ready && !leave_last)
          rack_cnt = 0;
      end
      else if (pad_biu_rack_ready)
        rack_cnt = 1;
      if (rack_cnt == 2)
        pend_seen++;
    end
  end

  // watchdog
  initial
  begin
    repeat (40 * n_total + 200) @(posedge arcpuclk);
    $display("timeout: traffic did not drain within %0d cycles", 40 * n_total + 200);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  //**************************************************************************
  // test sequence
  //**************************************************************************
  initial
  begin
    void'($urandom(32'he528));
    cpurst_b                 = 1'b0;
    arvalid                  = 1'b0;
    arid                     = '0;
    araddr                   = '0;
    arlen                    = '0;
    arsize                   = '0;
    arburst                  = '0;
    pad_biu_arready          = 1'b0;
    pad_biu_rvalid           = 1'b0;
    pad_biu_rid              = '0;
    pad_biu_rdata            = '0;
    pad_biu_rresp            = '0;
    pad_biu_rlast            = 1'b0;
    pad_biu_rack_ready       = 1'b0;
    lsu_biu_r_linefill_ready = 1'b0;
    ifu_biu_r_ready          = 1'b0;
    repeat (8) @(posedge arcpuclk);
    cpurst_b <= 1'b1;

    send_requests(n_ar);
    wait_drain();
    send_beats(n_mixed, 3, 1'b0);
    wait_drain();

    // a following load must not pass the held linefill
    lf_pct = 0;
    fork
      begin
        send_beats(1, 0, 1'b1);
        send_beats(3, 1, 1'b0);
      end
      begin
        repeat (12) @(posedge arcpuclk);
        lf_pct = 100;
      end
    join
    wait_drain();

    // fetch held by its ready
    ifu_pct = 0;
    fork
      send_beats(4, 2, 1'b0);
      begin
        repeat (12) @(posedge arcpuclk);
        ifu_pct = 100;
      end
    join
    wait_drain();

    // acknowledge path blocked across several last beats
    rack_pct = 0;
    fork
      send_beats(5, 1, 1'b1);
      begin
        repeat (16) @(posedge arcpuclk);
        rack_pct = 100;
      end
    join
    wait_drain();

    check_value("read_busy after drain", read_busy, 1'b0);
    check_value("acknowledges against last beats", ack_done, last_cnt);
    check_value("pending acknowledge reached", pend_seen > 0, 1'b1);
    check_value("data store filled", full_seen > 0, 1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- biu_read_channel.f
design/biu_read_pkg.sv
design/biu_r_slot_if.sv
design/biu_ar_buffer.sv
design/biu_r_push_ctl.sv
design/biu_r_slot.sv
design/biu_r_route.sv
design/biu_rack_gen.sv
design/biu_read_channel.sv
test/biu_read_channel_asserts.sv
test/tb_biu_read_channel.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_biu_read_channel
FILELIST  = biu_read_channel.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
